// File: pcs_am_tx.f
rtl/pcs_am_pkg.sv
rtl/idle_counter.sv
rtl/am_mod_counter.sv
rtl/sync_fifo.sv
rtl/clock_comp_tx.sv
rtl/am_inserter.sv
rtl/pcs_am_tx.sv
verif/pcs_am_tx_checker.sv
verif/pcs_am_tx_tb.sv

// File: rtl/am_inserter.sv
`timescale 1ns/100ps

module am_inserter (
	input  logic                   i_clock,
	input  logic                   i_arst_n,
	input  logic                   i_enable,
	input  pcs_am_pkg::cc_out_s    i_cc,
	output logic                   o_valid,
	output logic                   o_am_flag,
	output pcs_am_pkg::pcs_block_u o_block
);

	import pcs_am_pkg::*;

	logic [NB_LANE-1:0] lane;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid   <= 1'b0;
			o_am_flag <= 1'b0;
			lane      <= '0;
		end
		else if (i_enable) begin
			o_valid   <= i_cc.valid;
			o_am_flag <= i_cc.am;
			if (i_cc.am) begin
				if (lane == NB_LANE'(N_LANES - 1)) begin
					lane <= '0;
				end
				else begin
					lane <= lane + 1'b1;
				end
			end
		end
		else begin
			o_valid   <= 1'b0;
			o_am_flag <= 1'b0;
		end
	end

	// Marker slots take the entry of the current lane
	always_ff @(posedge i_clock) begin
		if (i_enable) begin
			if (i_cc.am) begin
				o_block <= AM_TABLE[lane];
			end
			else begin
				o_block <= i_cc.block;
			end
		end
	end

endmodule

// File: rtl/am_mod_counter.sv
`timescale 1ns/100ps

module am_mod_counter (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic i_enable,
	input  logic i_valid,
	output logic o_block_count_done,
	output logic o_insert_am,
	output logic o_read_enable
);

	import pcs_am_pkg::*;

	logic [NB_CNT-1:0]  block_cnt;
	logic [NB_LANE-1:0] am_cnt;
	logic               am_phase;
	logic               last_am;

	// Last accepted block of the period
	assign o_block_count_done = i_enable && i_valid && (block_cnt == NB_CNT'(N_BLOCKS - 1));
	assign last_am            = (am_cnt == NB_LANE'(N_LANES - 1));

	assign o_insert_am   = am_phase;
	assign o_read_enable = !am_phase;

	// Input blocks keep counting through the marker window
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			block_cnt <= '0;
		end
		else if (i_enable && i_valid) begin
			if (o_block_count_done) begin
				block_cnt <= '0;
			end
			else begin
				block_cnt <= block_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			am_phase <= 1'b0;
			am_cnt   <= '0;
		end
		else if (i_enable) begin
			if (am_phase) begin
				if (last_am) begin
					am_phase <= 1'b0;
					am_cnt   <= '0;
				end
				else begin
					am_cnt <= am_cnt + 1'b1;
				end
			end
			else if (o_block_count_done) begin
				am_phase <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/clock_comp_tx.sv
`timescale 1ns/100ps

module clock_comp_tx (
	input  logic                   i_clock,
	input  logic                   i_arst_n,
	input  logic                   i_enable,
	input  logic                   i_valid,
	input  pcs_am_pkg::pcs_block_u i_block,
	output pcs_am_pkg::cc_out_s    o_cc
);

	import pcs_am_pkg::*;

	logic       idle_detected;
	logic       idle_drop;
	logic       idle_count_done;
	logic       block_count_done;
	logic       insert_am;
	logic       read_enable;
	logic       fifo_write;
	logic       fifo_empty;
	logic       fifo_full;
	pcs_block_u fifo_data;

	idle_counter u_idle_counter (
		.i_clock            (i_clock),
		.i_arst_n           (i_arst_n),
		.i_enable           (i_enable),
		.i_idle_drop        (idle_drop),
		.i_block_count_done (block_count_done),
		.o_idle_count_done  (idle_count_done)
	);

	am_mod_counter u_am_mod_counter (
		.i_clock            (i_clock),
		.i_arst_n           (i_arst_n),
		.i_enable           (i_enable),
		.i_valid            (i_valid),
		.o_block_count_done (block_count_done),
		.o_insert_am        (insert_am),
		.o_read_enable      (read_enable)
	);

	sync_fifo u_sync_fifo (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.i_enable (i_enable),
		.i_write  (fifo_write),
		.i_read   (read_enable),
		.i_data   (i_block),
		.o_empty  (fifo_empty),
		.o_full   (fifo_full),
		.o_data   (fifo_data)
	);

	assign idle_detected = i_valid && (i_block.ctrl.sh == SH_CTRL)
		&& (i_block.ctrl.btype == BT_IDLE) && (i_block.ctrl.payload == '0);

	// Drop idles until the quota of this period is met
	assign idle_drop  = idle_detected && !idle_count_done;
	assign fifo_write = i_valid && !idle_drop;

	always_comb begin
		o_cc.valid = insert_am || !fifo_empty;
		o_cc.am    = insert_am;
		if (!insert_am && !fifo_empty) begin
			o_cc.block = fifo_data;
		end
		else begin
			o_cc.block = PCS_IDLE;
		end
	end

endmodule

// File: rtl/idle_counter.sv
`timescale 1ns/100ps

module idle_counter (
	input  logic i_clock,
	input  logic i_arst_n,
	input  logic i_enable,
	input  logic i_idle_drop,
	input  logic i_block_count_done,
	output logic o_idle_count_done
);

	import pcs_am_pkg::*;

	logic [NB_IDLE-1:0] idle_count;

	assign o_idle_count_done = (idle_count == NB_IDLE'(N_IDLE));

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			idle_count <= '0;
		end
		else if (i_enable) begin
			// New period wins over a drop in the same cycle
			if (i_block_count_done) begin
				idle_count <= '0;
			end
			else if (i_idle_drop && !o_idle_count_done) begin
				idle_count <= idle_count + 1'b1;
			end
		end
	end

endmodule

// File: rtl/pcs_am_pkg.sv
package pcs_am_pkg;

	localparam int NB_DATA  = 66;
	localparam int NB_SH    = 2;
	localparam int NB_BTYPE = 8;
	localparam int N_LANES  = 20;
	// Must track N_LANES to keep the rate balanced
	localparam int N_IDLE   = N_LANES;
	// Scaled down from 16383 for simulation
	localparam int N_BLOCKS = 64;
	localparam int NB_ADDR  = $clog2(N_IDLE) + 1;
	localparam int NB_CNT   = $clog2(N_BLOCKS);
	localparam int NB_LANE  = $clog2(N_LANES);
	localparam int NB_IDLE  = $clog2(N_IDLE + 1);

	localparam logic [NB_SH-1:0]    SH_DATA = 2'b01;
	localparam logic [NB_SH-1:0]    SH_CTRL = 2'b10;
	localparam logic [NB_BTYPE-1:0] BT_IDLE = 8'h1E;

	typedef struct packed {
		logic [NB_SH-1:0]         sh;
		logic [NB_DATA-NB_SH-1:0] payload;
	} pcs_data_s;

	typedef struct packed {
		logic [NB_SH-1:0]                  sh;
		logic [NB_BTYPE-1:0]               btype;
		logic [NB_DATA-NB_SH-NB_BTYPE-1:0] payload;
	} pcs_ctrl_s;

	typedef union packed {
		pcs_data_s data;
		pcs_ctrl_s ctrl;
	} pcs_block_u;

	typedef struct packed {
		logic       valid;
		logic       am;
		pcs_block_u block;
	} cc_out_s;

	localparam logic [NB_DATA-1:0] PCS_IDLE = {SH_CTRL, BT_IDLE, 56'h0};

	// M0 M1 M2 BIP3 ~M0 ~M1 ~M2 BIP7
	// BIP fields left at zero
	localparam logic [NB_DATA-1:0] AM_TABLE [N_LANES] = '{
		66'h2_C16821_00_3E97DE_00, 66'h2_9D718E_00_628E71_00,
		66'h2_594BE8_00_A6B417_00, 66'h2_4D957B_00_B26A84_00,
		66'h2_F50709_00_0AF8F6_00, 66'h2_DD14C2_00_22EB3D_00,
		66'h2_9A4A26_00_65B5D9_00, 66'h2_7B4566_00_84BA99_00,
		66'h2_A02476_00_5FDB89_00, 66'h2_68C9FB_00_973604_00,
		66'h2_FD6C99_00_029366_00, 66'h2_B99155_00_466EAA_00,
		66'h2_5CB9B2_00_A3464D_00, 66'h2_1AF8BD_00_E50742_00,
		66'h2_83C7CA_00_7C3835_00, 66'h2_3536CD_00_CAC932_00,
		66'h2_C4314C_00_3BCEB3_00, 66'h2_ADD6B7_00_522948_00,
		66'h2_5F662A_00_A099D5_00, 66'h2_C0F0E5_00_3F0F1A_00
	};

endpackage

// File: rtl/pcs_am_tx.sv
`timescale 1ns/100ps

module pcs_am_tx (
	input  logic                   i_clock,
	input  logic                   i_arst_n,
	input  logic                   i_enable,
	input  logic                   i_valid,
	input  pcs_am_pkg::pcs_block_u i_block,
	output logic                   o_valid,
	output logic                   o_am_flag,
	output pcs_am_pkg::pcs_block_u o_block
);

	import pcs_am_pkg::*;

	cc_out_s cc;

	clock_comp_tx u_clock_comp_tx (
		.i_clock  (i_clock),
		.i_arst_n (i_arst_n),
		.i_enable (i_enable),
		.i_valid  (i_valid),
		.i_block  (i_block),
		.o_cc     (cc)
	);

	am_inserter u_am_inserter (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_enable  (i_enable),
		.i_cc      (cc),
		.o_valid   (o_valid),
		.o_am_flag (o_am_flag),
		.o_block   (o_block)
	);

endmodule

// File: rtl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo (
	input  logic                   i_clock,
	input  logic                   i_arst_n,
	input  logic                   i_enable,
	input  logic                   i_write,
	input  logic                   i_read,
	input  pcs_am_pkg::pcs_block_u i_data,
	output logic                   o_empty,
	output logic                   o_full,
	output pcs_am_pkg::pcs_block_u o_data
);

	import pcs_am_pkg::*;

	localparam int DEPTH = 2 ** NB_ADDR;

	pcs_block_u         mem [DEPTH];
	logic [NB_ADDR-1:0] wr_ptr;
	logic [NB_ADDR-1:0] rd_ptr;
	logic [NB_ADDR:0]   count;
	logic               do_write;
	logic               do_read;

	assign o_empty = (count == '0);
	assign o_full  = (count == (NB_ADDR + 1)'(DEPTH));

	assign do_write = i_enable && i_write && !o_full;
	assign do_read  = i_enable && i_read && !o_empty;

	// Head is visible before the read strobe
	assign o_data = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the pcs_am_tx testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module pcs_am_tx_tb -f pcs_am_tx.f -o pcs_am_tx_sim

# Result is decided from the log
./obj_dir/pcs_am_tx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

// File: verif/pcs_am_tx_checker.sv
`timescale 1ns/100ps

module pcs_am_tx_checker (
	input logic i_clock,
	input logic i_arst_n,
	input logic i_enable,
	input logic i_fifo_write,
	input logic i_fifo_full,
	input logic i_insert_am,
	input logic i_read_enable
);

	import pcs_am_pkg::*;

	logic [NB_LANE:0] win_len;

	// Enabled cycles spent in the current marker window
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			win_len <= '0;
		end
		else if (i_enable) begin
			if (i_insert_am) begin
				win_len <= win_len + 1'b1;
			end
			else begin
				win_len <= '0;
			end
		end
	end

	no_write_when_full: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_enable && i_fifo_full) |-> !i_fifo_write)
		else $error("FIFO written while full");

	window_not_too_long: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_insert_am |-> (win_len < N_LANES))
		else $error("Marker window longer than N_LANES cycles");

	window_full_length: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		(i_enable && !i_insert_am && win_len != '0) |-> (win_len == N_LANES))
		else $error("Marker window shorter than N_LANES cycles");

	no_read_in_window: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		i_insert_am |-> !i_read_enable)
		else $error("FIFO read enabled inside the marker window");

endmodule

bind clock_comp_tx pcs_am_tx_checker u_checker (
	.i_clock       (i_clock),
	.i_arst_n      (i_arst_n),
	.i_enable      (i_enable),
	.i_fifo_write  (fifo_write),
	.i_fifo_full   (fifo_full),
	.i_insert_am   (insert_am),
	.i_read_enable (read_enable)
);

// File: verif/pcs_am_tx_tb.sv
`timescale 1ns/100ps

module pcs_am_tx_tb;

	import pcs_am_pkg::*;

	typedef enum bit {KIND_DATA, KIND_IDLE} kind_e;

	logic       i_clock;
	logic       i_arst_n;
	logic       i_enable;
	logic       i_valid;
	pcs_block_u i_block;
	logic       o_valid;
	logic       o_am_flag;
	pcs_block_u o_block;

	// Valid duty in eighths of the clock rate
	string test_name [10] = '{"quiet", "data_full", "idle_full", "data_half", "idle_sparse",
		"data_long", "idle_after_long", "data_burst", "idle_tail", "data_tail"};
	kind_e row_kind [10] = '{KIND_DATA, KIND_DATA, KIND_IDLE, KIND_DATA, KIND_IDLE,
		KIND_DATA, KIND_IDLE, KIND_DATA, KIND_IDLE, KIND_DATA};
	int    row_len  [10] = '{8, 40, 60, 80, 40, 150, 50, 30, 70, 64};
	int    row_duty [10] = '{0, 8, 8, 4, 3, 5, 8, 8, 6, 4};

	logic [15:0]        lfsr;
	logic [NB_DATA-1:0] model_q [$];
	string              cur_name = "reset";
	bit                 input_seen;
	int                 accepted;
	int                 in_period;
	int                 drops;
	int                 am_run;
	int                 am_runs;

	pcs_am_tx UUT (
		.i_clock   (i_clock),
		.i_arst_n  (i_arst_n),
		.i_enable  (i_enable),
		.i_valid   (i_valid),
		.i_block   (i_block),
		.o_valid   (o_valid),
		.o_am_flag (o_am_flag),
		.o_block   (o_block)
	);

	initial begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	task automatic stop_failed();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic fail_run(input string why);
		$display("Error: %s", why);
		stop_failed();
	endtask

	task automatic value_mismatch(input string test, input logic [NB_DATA-1:0] exp,
		input logic [NB_DATA-1:0] act);
		$display("** Error %s: expected %h, actual %h", test, exp, act);
		stop_failed();
	endtask

	// 16-bit Galois LFSR
	function automatic logic [63:0] draw_bits(input int n);
		logic [63:0] bits;
		bits = '0;
		for (int k = 0; k < n; k++) begin
			bits = {bits[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return bits;
	endfunction

	// First N_IDLE idles of every N_BLOCKS valid inputs vanish
	task automatic model_accept(input kind_e kind, input logic [NB_DATA-1:0] blk);
		if (kind == KIND_IDLE && drops < N_IDLE) begin
			drops++;
		end
		else begin
			model_q.push_back(blk);
		end
		accepted++;
		in_period++;
		if (in_period == N_BLOCKS) begin
			in_period = 0;
			drops     = 0;
		end
	endtask

	task automatic drive_cycle(input kind_e kind, input int duty);
		logic [63:0]        r;
		logic [NB_DATA-1:0] blk;
		r = draw_bits(3);
		if (r < 64'(duty)) begin
			if (kind == KIND_IDLE) begin
				blk = PCS_IDLE;
			end
			else begin
				r   = draw_bits(64);
				blk = {SH_DATA, r};
			end
			i_valid    = 1'b1;
			i_block    = blk;
			input_seen = 1'b1;
			model_accept(kind, blk);
		end
		else begin
			i_valid = 1'b0;
		end
	endtask

	always @(negedge i_clock) begin : monitor
		logic [NB_DATA-1:0] exp;
		if (!i_arst_n || !input_seen) begin
			assert (!o_valid && !o_am_flag)
				else fail_run("output active before any valid input");
		end
		else if (o_am_flag) begin
			assert (o_valid && am_run < N_LANES)
				else fail_run("marker slot invalid or marker run longer than N_LANES");
			exp = AM_TABLE[am_run];
			assert (o_block === exp)
				else value_mismatch($sformatf("%s marker lane %0d", cur_name, am_run),
					exp, o_block);
			am_run++;
		end
		else begin
			if (am_run != 0) begin
				assert (am_run == N_LANES) else fail_run("marker run shorter than N_LANES");
				am_runs++;
				am_run = 0;
			end
			if (o_valid) begin
				assert (model_q.size() > 0) else fail_run("output block not expected by model");
				exp = model_q.pop_front();
				assert (o_block === exp) else value_mismatch(cur_name, exp, o_block);
			end
		end
	end

	initial begin
		lfsr     = 16'd44972;
		i_arst_n = 1'b0;
		i_enable = 1'b1;
		i_valid  = 1'b0;
		i_block  = '0;
		repeat (5) @(posedge i_clock);
		@(negedge i_clock);
		i_arst_n = 1'b1;
		for (int t = 0; t < $size(row_len); t++) begin
			cur_name = test_name[t];
			for (int c = 0; c < row_len[t]; c++) begin
				@(negedge i_clock);
				drive_cycle(row_kind[t], row_duty[t]);
			end
		end
		@(negedge i_clock);
		i_valid  = 1'b0;
		cur_name = "drain";
		while (model_q.size() != 0 || o_am_flag) begin
			@(negedge i_clock);
		end
		// Last window may open just after the final input
		repeat (N_LANES + 4) @(negedge i_clock);
		assert (am_run == 0) else fail_run("marker run still open at end of test");
		assert (am_runs == accepted / N_BLOCKS)
			else value_mismatch("marker_runs", NB_DATA'(accepted / N_BLOCKS), NB_DATA'(am_runs));
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Table length with margin and one marker window per period
	initial begin : watchdog
		int total;
		int limit;
		total = 0;
		foreach (row_len[t]) begin
			total += row_len[t];
		end
		limit = 5 + 2 * total + (total / N_BLOCKS + 1) * (N_LANES + 4);
		repeat (limit) @(posedge i_clock);
		fail_run("watchdog timeout, the test did not finish in time");
	end

endmodule
